// ==== include/rbi_defines.svh ====
`ifndef RBI_DEFINES_SVH
`define RBI_DEFINES_SVH

////////////////////////////////////////////////////////////
// geometry constants, all Q16.16
////////////////////////////////////////////////////////////

// half edge of a block, 100.0
`define RBI_BLOCK_HALF 32'sh0064_0000

// slab interval limits, -30000.0 and +30000.0
`define RBI_T_MIN 32'sh8AD0_0000
`define RBI_T_MAX 32'sh7530_0000

////////////////////////////////////////////////////////////
// flow control
////////////////////////////////////////////////////////////

// output queue slots, also the upstream credit count at reset
`define RBI_FIFO_DEPTH 8
`define RBI_OUT_CREDITS 4

`endif

// ==== src/rbi_fixed_pkg.sv ====
package rbi_fixed_pkg;

    ////////////////////////////////////////////////////////////
    // fixed point value types
    ////////////////////////////////////////////////////////////

    // signed Q16.16 coordinate or distance
    typedef logic signed [31:0] fixed_t;

    // full product of two fixed_t values, Q32.32
    typedef logic signed [63:0] wide_t;

    // fraction bits in fixed_t
    localparam int unsigned FRAC_BITS = 16;

endpackage

// ==== src/rbi_stream_pkg.sv ====
package rbi_stream_pkg;

    ////////////////////////////////////////////////////////////
    // credit and queue bookkeeping types
    ////////////////////////////////////////////////////////////

    // downstream credits held by the unit
    typedef logic [3:0] credit_cnt_t;

    // read or write position in the output queue
    typedef logic [2:0] fifo_ptr_t;

    // queue fill level, needs one bit more than the pointer
    typedef logic [3:0] fifo_cnt_t;

endpackage

// ==== src/rbi_if.sv ====
`timescale 1ns/1ps

// corners of the block, ray inverse direction and best distance so far
interface rbi_box_if;
    logic                  valid;
    rbi_fixed_pkg::fixed_t bmin_x, bmin_y, bmin_z;
    rbi_fixed_pkg::fixed_t bmax_x, bmax_y, bmax_z;
    rbi_fixed_pkg::fixed_t inv_x, inv_y, inv_z;
    rbi_fixed_pkg::fixed_t t_best;

    modport source (
        output valid, bmin_x, bmin_y, bmin_z, bmax_x, bmax_y, bmax_z,
        output inv_x, inv_y, inv_z, t_best
    );
    modport sink (
        input valid, bmin_x, bmin_y, bmin_z, bmax_x, bmax_y, bmax_z,
        input inv_x, inv_y, inv_z, t_best
    );
endinterface

// slab entry and exit distances per axis
interface rbi_slab_if;
    logic                  valid;
    rbi_fixed_pkg::fixed_t t1_x, t2_x;
    rbi_fixed_pkg::fixed_t t1_y, t2_y;
    rbi_fixed_pkg::fixed_t t1_z, t2_z;
    rbi_fixed_pkg::fixed_t t_best;

    modport source (output valid, t1_x, t2_x, t1_y, t2_y, t1_z, t2_z, t_best);
    modport sink (input valid, t1_x, t2_x, t1_y, t2_y, t1_z, t2_z, t_best);
endinterface

// reduced interval of the ray inside the block
interface rbi_span_if;
    logic                  valid;
    rbi_fixed_pkg::fixed_t t_near;
    rbi_fixed_pkg::fixed_t t_far;
    rbi_fixed_pkg::fixed_t t_best;

    modport source (output valid, t_near, t_far, t_best);
    modport sink (input valid, t_near, t_far, t_best);
endinterface

// ==== src/rbi_bounds.sv ====
`timescale 1ns/1ps
`include "rbi_defines.svh"

module rbi_bounds (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  in_valid,
    input  rbi_fixed_pkg::fixed_t block_pos_x,
    input  rbi_fixed_pkg::fixed_t block_pos_y,
    input  rbi_fixed_pkg::fixed_t block_pos_z,
    input  rbi_fixed_pkg::fixed_t inv_x,
    input  rbi_fixed_pkg::fixed_t inv_y,
    input  rbi_fixed_pkg::fixed_t inv_z,
    input  rbi_fixed_pkg::fixed_t t_in,
    rbi_box_if.source             box
);

    localparam rbi_fixed_pkg::fixed_t BLOCK_HALF = `RBI_BLOCK_HALF;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            box.valid <= 1'b0;
        end else begin
            box.valid <= in_valid;
        end
    end

    // cube faces lie one half size either side of the centre
    always_ff @(posedge clk_in) begin
        box.bmin_x <= block_pos_x - BLOCK_HALF;
        box.bmin_y <= block_pos_y - BLOCK_HALF;
        box.bmin_z <= block_pos_z - BLOCK_HALF;
        box.bmax_x <= block_pos_x + BLOCK_HALF;
        box.bmax_y <= block_pos_y + BLOCK_HALF;
        box.bmax_z <= block_pos_z + BLOCK_HALF;
        // ray and best distance ride along
        box.inv_x  <= inv_x;
        box.inv_y  <= inv_y;
        box.inv_z  <= inv_z;
        box.t_best <= t_in;
    end

endmodule

// ==== src/rbi_slab_mul.sv ====
`timescale 1ns/1ps

module rbi_slab_mul (
    input  logic      clk_in,
    input  logic      rst_in,
    rbi_box_if.sink   box,
    rbi_slab_if.source slab
);

    ////////////////////////////////////////////////////////////
    // Q16.16 multiply
    ////////////////////////////////////////////////////////////

    // full 64 bit product, then drop the extra fraction bits
    // overflow above Q16.16 simply wraps
    function automatic rbi_fixed_pkg::fixed_t fx_mul(
        input rbi_fixed_pkg::fixed_t a,
        input rbi_fixed_pkg::fixed_t b
    );
        rbi_fixed_pkg::wide_t full;
        full = rbi_fixed_pkg::wide_t'(a) * rbi_fixed_pkg::wide_t'(b);
        return full[rbi_fixed_pkg::FRAC_BITS +: 32];
    endfunction

    rbi_fixed_pkg::fixed_t t1_x, t2_x;
    rbi_fixed_pkg::fixed_t t1_y, t2_y;
    rbi_fixed_pkg::fixed_t t1_z, t2_z;

    // distance to each face plane, origin is at zero
    always_comb begin
        t1_x = fx_mul(box.bmin_x, box.inv_x);
        t2_x = fx_mul(box.bmax_x, box.inv_x);
        t1_y = fx_mul(box.bmin_y, box.inv_y);
        t2_y = fx_mul(box.bmax_y, box.inv_y);
        t1_z = fx_mul(box.bmin_z, box.inv_z);
        t2_z = fx_mul(box.bmax_z, box.inv_z);
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            slab.valid <= 1'b0;
        end else begin
            slab.valid <= box.valid;
        end
    end

    always_ff @(posedge clk_in) begin
        slab.t1_x   <= t1_x;
        slab.t2_x   <= t2_x;
        slab.t1_y   <= t1_y;
        slab.t2_y   <= t2_y;
        slab.t1_z   <= t1_z;
        slab.t2_z   <= t2_z;
        slab.t_best <= box.t_best;
    end

endmodule

// ==== src/rbi_slab_reduce.sv ====
`timescale 1ns/1ps
`include "rbi_defines.svh"

module rbi_slab_reduce (
    input  logic       clk_in,
    input  logic       rst_in,
    rbi_slab_if.sink   slab,
    rbi_span_if.source span
);

    function automatic rbi_fixed_pkg::fixed_t fx_min(
        input rbi_fixed_pkg::fixed_t a,
        input rbi_fixed_pkg::fixed_t b
    );
        return (a < b) ? a : b;
    endfunction

    function automatic rbi_fixed_pkg::fixed_t fx_max(
        input rbi_fixed_pkg::fixed_t a,
        input rbi_fixed_pkg::fixed_t b
    );
        return (a > b) ? a : b;
    endfunction

    localparam rbi_fixed_pkg::fixed_t T_MIN = `RBI_T_MIN;
    localparam rbi_fixed_pkg::fixed_t T_MAX = `RBI_T_MAX;

    ////////////////////////////////////////////////////////////
    // stage 2, order each slab pair
    ////////////////////////////////////////////////////////////

    logic                  valid_a;
    rbi_fixed_pkg::fixed_t t_best_a;
    rbi_fixed_pkg::fixed_t lo_x, lo_y, lo_z;
    rbi_fixed_pkg::fixed_t hi_x, hi_y, hi_z;

    always_ff @(posedge clk_in) begin
        lo_x     <= fx_min(slab.t1_x, slab.t2_x);
        hi_x     <= fx_max(slab.t1_x, slab.t2_x);
        lo_y     <= fx_min(slab.t1_y, slab.t2_y);
        hi_y     <= fx_max(slab.t1_y, slab.t2_y);
        lo_z     <= fx_min(slab.t1_z, slab.t2_z);
        hi_z     <= fx_max(slab.t1_z, slab.t2_z);
        t_best_a <= slab.t_best;
    end

    ////////////////////////////////////////////////////////////
    // stage 3, reduce to entry and exit
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        span.t_near <= fx_max(fx_max(T_MIN, lo_x), fx_max(lo_y, lo_z));
        span.t_far  <= fx_min(fx_min(T_MAX, hi_x), fx_min(hi_y, hi_z));
        span.t_best <= t_best_a;
    end

    // valid follows the two payload stages
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_a    <= 1'b0;
            span.valid <= 1'b0;
        end else begin
            valid_a    <= slab.valid;
            span.valid <= valid_a;
        end
    end

endmodule

// ==== src/rbi_hit_decide.sv ====
`timescale 1ns/1ps

module rbi_hit_decide (
    input  logic                  clk_in,
    input  logic                  rst_in,
    rbi_span_if.sink              span,
    output logic                  res_valid,
    output logic                  res_hit,
    output rbi_fixed_pkg::fixed_t res_t
);

    logic hit;

    // interval not empty, not fully behind the origin,
    // and closer than what the ray already has
    always_comb begin
        hit = (span.t_near <= span.t_far)
            && (span.t_far >= 0)
            && (span.t_near < span.t_best);
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= span.valid;
        end
    end

    always_ff @(posedge clk_in) begin
        res_hit <= hit;
        if (hit) begin
            res_t <= span.t_near;
        end else begin
            // keep the previous best
            res_t <= span.t_best;
        end
    end

endmodule

// ==== src/rbi_credit_out.sv ====
`timescale 1ns/1ps
`include "rbi_defines.svh"

module rbi_credit_out (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  res_valid,
    input  logic                  res_hit,
    input  rbi_fixed_pkg::fixed_t res_t,
    input  logic                  out_credit,
    output logic                  out_valid,
    output logic                  out_hit,
    output rbi_fixed_pkg::fixed_t out_t,
    output logic                  in_credit
);

    ////////////////////////////////////////////////////////////
    // result queue
    ////////////////////////////////////////////////////////////

    logic                  mem_hit [`RBI_FIFO_DEPTH];
    rbi_fixed_pkg::fixed_t mem_t   [`RBI_FIFO_DEPTH];

    rbi_stream_pkg::fifo_ptr_t   wr_ptr, rd_ptr;
    rbi_stream_pkg::fifo_cnt_t   fifo_cnt;
    rbi_stream_pkg::credit_cnt_t credit_cnt;

    logic pop;

    // pop when an entry waits and downstream has a credit
    assign pop = (fifo_cnt != '0) && (credit_cnt != '0);

    always_ff @(posedge clk_in) begin
        if (res_valid) begin
            mem_hit[wr_ptr] <= res_hit;
            mem_t[wr_ptr]   <= res_t;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_cnt   <= '0;
            credit_cnt <= rbi_stream_pkg::credit_cnt_t'(`RBI_OUT_CREDITS);
        end else begin
            if (res_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({res_valid, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
            // one credit back from downstream and one spent per beat
            case ({out_credit, pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // registered output beat
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            out_valid <= pop;
            in_credit <= pop;
        end
    end

    always_ff @(posedge clk_in) begin
        if (pop) begin
            out_hit <= mem_hit[rd_ptr];
            out_t   <= mem_t[rd_ptr];
        end
    end

    // upstream must never send more rays than there are free slots
    a_no_write_full: assert property (@(posedge clk_in) disable iff (rst_in)
        res_valid |-> (fifo_cnt != rbi_stream_pkg::fifo_cnt_t'(`RBI_FIFO_DEPTH)));

    // downstream returns no more than it was given
    a_credit_max: assert property (@(posedge clk_in) disable iff (rst_in)
        credit_cnt <= rbi_stream_pkg::credit_cnt_t'(`RBI_OUT_CREDITS));

    // a beat drains an entry that the pointers show as stored
    a_out_after_pop: assert property (@(posedge clk_in) disable iff (rst_in)
        out_valid |-> $past((wr_ptr != rd_ptr)
            || (fifo_cnt == rbi_stream_pkg::fifo_cnt_t'(`RBI_FIFO_DEPTH))));

endmodule

// ==== src/rbi_top.sv ====
`timescale 1ns/1ps

module rbi_top (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  in_valid,
    input  rbi_fixed_pkg::fixed_t block_pos_x,
    input  rbi_fixed_pkg::fixed_t block_pos_y,
    input  rbi_fixed_pkg::fixed_t block_pos_z,
    input  rbi_fixed_pkg::fixed_t ray_inv_x,
    input  rbi_fixed_pkg::fixed_t ray_inv_y,
    input  rbi_fixed_pkg::fixed_t ray_inv_z,
    input  rbi_fixed_pkg::fixed_t t_in,
    output logic                  in_credit,
    output logic                  out_valid,
    output logic                  out_hit,
    output rbi_fixed_pkg::fixed_t out_t,
    input  logic                  out_credit
);

    rbi_box_if  box_if ();
    rbi_slab_if slab_if ();
    rbi_span_if span_if ();

    // decided result into the queue
    logic                  res_valid;
    logic                  res_hit;
    rbi_fixed_pkg::fixed_t res_t;

    ////////////////////////////////////////////////////////////
    // five cycle intersection pipeline
    ////////////////////////////////////////////////////////////

    rbi_bounds bounds_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .in_valid    (in_valid),
        .block_pos_x (block_pos_x),
        .block_pos_y (block_pos_y),
        .block_pos_z (block_pos_z),
        .inv_x       (ray_inv_x),
        .inv_y       (ray_inv_y),
        .inv_z       (ray_inv_z),
        .t_in        (t_in),
        .box         (box_if.source)
    );

    rbi_slab_mul slab_mul_i (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .box    (box_if.sink),
        .slab   (slab_if.source)
    );

    rbi_slab_reduce slab_reduce_i (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .slab   (slab_if.sink),
        .span   (span_if.source)
    );

    rbi_hit_decide hit_decide_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .span      (span_if.sink),
        .res_valid (res_valid),
        .res_hit   (res_hit),
        .res_t     (res_t)
    );

    // queue and credits on both sides
    rbi_credit_out credit_out_i (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .res_valid  (res_valid),
        .res_hit    (res_hit),
        .res_t      (res_t),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_hit    (out_hit),
        .out_t      (out_t),
        .in_credit  (in_credit)
    );

endmodule

// ==== bench/rbi_tb.sv ====
`timescale 1ns/1ps
`include "rbi_defines.svh"

module rbi_tb;

    localparam int N_PAT      = 14;
    localparam int N_COL      = 9;
    localparam int MAX_CYCLES = N_PAT * 40 + 100;

    logic                  clk_in, rst_in, in_valid, out_credit;
    logic                  in_credit, out_valid, out_hit;
    rbi_fixed_pkg::fixed_t block_pos_x, block_pos_y, block_pos_z;
    rbi_fixed_pkg::fixed_t ray_inv_x, ray_inv_y, ray_inv_z;
    rbi_fixed_pkg::fixed_t t_in, out_t;

    // nine words per ray in file order
    logic [31:0]           pat_mem [N_PAT * N_COL];
    bit                    exp_hit_q [$];
    rbi_fixed_pkg::fixed_t exp_t_q [$];

    int          up_credits   = `RBI_FIFO_DEPTH;
    int          sent         = 0;
    int          delivered    = 0;
    int          credits_back = 0;
    int          returned     = 0;
    int          cycles       = 0;
    bit          return_en    = 1'b0;
    int unsigned lcg_state;

    rbi_top dut_i (.*);

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    function automatic int unsigned next_random(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_hit(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %0b, expected %0b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_t(input string name, input rbi_fixed_pkg::fixed_t got,
                           input rbi_fixed_pkg::fixed_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // starts just after a rising edge and returns just after the next one
    task automatic drive_ray(input int idx);
        int base;
        base = idx * N_COL;
        while (up_credits == 0) begin
            in_valid = 1'b0;
            @(posedge clk_in);
            #1;
        end
        in_valid    = 1'b1;
        block_pos_x = pat_mem[base];
        block_pos_y = pat_mem[base + 1];
        block_pos_z = pat_mem[base + 2];
        ray_inv_x   = pat_mem[base + 3];
        ray_inv_y   = pat_mem[base + 4];
        ray_inv_z   = pat_mem[base + 5];
        t_in        = pat_mem[base + 6];
        exp_hit_q.push_back(pat_mem[base + 7][0]);
        exp_t_q.push_back(pat_mem[base + 8]);
        up_credits--;
        sent++;
        @(posedge clk_in);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // result monitor on the falling edge where outputs are stable
    ////////////////////////////////////////////////////////////

    always @(negedge clk_in) begin
        if (!rst_in && out_valid) begin
            if (exp_t_q.size() == 0) begin
                $display("Error at %0t ns: result beat with no ray outstanding", $time);
                stop_run();
            end else begin
                check_hit("out_hit", out_hit, exp_hit_q.pop_front());
                check_t("out_t", out_t, exp_t_q.pop_front());
                delivered++;
            end
            if (!return_en && delivered > `RBI_OUT_CREDITS) begin
                $display("Error at %0t ns: result sent with no downstream credit", $time);
                stop_run();
            end
        end
        if (!rst_in && in_credit) begin
            credits_back++;
            up_credits++;
            if (credits_back > delivered) begin
                $display("Error at %0t ns: more credits returned than results", $time);
                stop_run();
            end
        end
    end

    // downstream hands credits back at random
    initial begin
        forever begin
            @(posedge clk_in);
            #1;
            out_credit = 1'b0;
            if (return_en && returned < delivered) begin
                lcg_state = next_random(lcg_state);
                if (lcg_state[16]) begin
                    out_credit = 1'b1;
                    returned++;
                end
            end
        end
    end

    always @(posedge clk_in) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Error at %0t ns: run did not finish in %0d cycles", $time, MAX_CYCLES);
            stop_run();
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        $readmemh("bench/rbi_patterns.txt", pat_mem);
        rst_in      = 1'b1;
        in_valid    = 1'b0;
        out_credit  = 1'b0;
        block_pos_x = '0;
        block_pos_y = '0;
        block_pos_z = '0;
        ray_inv_x   = '0;
        ray_inv_y   = '0;
        ray_inv_z   = '0;
        t_in        = '0;
        lcg_state   = 74;
        repeat (3) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        @(negedge clk_in);
        check_hit("out_valid", out_valid, 1'b0);
        check_hit("in_credit", in_credit, 1'b0);
        @(posedge clk_in);
        #1;
        fork
            // two passes back to back with the first stalling on credits
            begin
                for (int pass = 0; pass < 2; pass++) begin
                    for (int i = 0; i < N_PAT; i++) begin
                        drive_ray(i);
                    end
                end
                in_valid = 1'b0;
            end
            begin
                while (delivered < `RBI_OUT_CREDITS) @(posedge clk_in);
                // wait longer than the pipeline so a stray beat would show
                repeat (20) @(posedge clk_in);
                if (delivered != `RBI_OUT_CREDITS
                        || sent != `RBI_FIFO_DEPTH + `RBI_OUT_CREDITS) begin
                    $display("Error at %0t ns: %0d results and %0d rays under back-pressure",
                             $time, delivered, sent);
                    stop_run();
                end else begin
                    return_en = 1'b1;
                end
            end
        join
        while (delivered < sent) @(posedge clk_in);
        @(posedge clk_in);
        if (up_credits != `RBI_FIFO_DEPTH) begin
            $display("Error at %0t ns: upstream holds %0d credits at the end instead of %0d",
                     $time, up_credits, `RBI_FIFO_DEPTH);
            stop_run();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// ==== bench/rbi_patterns.txt ====
// pos_x pos_y pos_z inv_x inv_y inv_z t_in exp_hit exp_t
// all values Q16.16 hex, one ray per row
012C0000 012C0000 012C0000 00010000 00010000 00010000 03E80000 00000001 00C80000
012C0000 00FA0000 01400000 00010000 00010000 00010000 03E80000 00000001 00DC0000
012C0000 012C0000 012C0000 00008000 00008000 00008000 03E80000 00000001 00640000
FED40000 FED40000 FED40000 FFFF0000 FFFF0000 FFFF0000 03E80000 00000001 00C80000
012C0000 02580000 012C0000 00010000 00010000 00010000 03E80000 00000000 03E80000
012C0000 00000000 00000000 00010000 00010000 00010000 03E80000 00000000 03E80000
012C0000 012C0000 012C0000 00010000 00010000 00010000 00960000 00000000 00960000
012C0000 012C0000 012C0000 00010000 00010000 00010000 00C80000 00000000 00C80000
FED40000 FED40000 FED40000 00010000 00010000 00010000 03E80000 00000000 03E80000
00320000 00320000 00320000 00010000 00010000 00010000 03E80000 00000001 FFCE0000
00960000 012C0000 02580000 00020000 00010000 00008000 03E80000 00000001 00FA0000
FED40000 012C0000 012C0000 FFFF0000 00010000 00010000 03E80000 00000001 00C80000
012C8000 012C0000 012C0000 00010000 00010000 00010000 03E80000 00000001 00C88000
012C0000 012C0000 012C0000 00010000 00010000 00010000 00C80001 00000001 00C80000

// ==== flist.f ====
+incdir+include
src/rbi_fixed_pkg.sv
src/rbi_stream_pkg.sv
src/rbi_if.sv
src/rbi_bounds.sv
src/rbi_slab_mul.sv
src/rbi_slab_reduce.sv
src/rbi_hit_decide.sv
src/rbi_credit_out.sv
src/rbi_top.sv
bench/rbi_tb.sv

// ==== Bender.yml ====
package:
  name: rbi

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/rbi_fixed_pkg.sv
      - src/rbi_stream_pkg.sv
      - src/rbi_if.sv
      - src/rbi_bounds.sv
      - src/rbi_slab_mul.sv
      - src/rbi_slab_reduce.sv
      - src/rbi_hit_decide.sv
      - src/rbi_credit_out.sv
      - src/rbi_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/rbi_tb.sv
